// ==== hdl/ppu_timing_pkg.sv ====
`default_nettype none

package ppu_timing_pkg;

  // NTSC raster geometry
  localparam int DOTS_PER_LINE   = 341;
  localparam int LINES_PER_FRAME = 262;
  localparam int VISIBLE_LINES   = 240;
  localparam int VBLANK_LINE     = 241;
  localparam int SCREEN_WIDTH    = 256;

  typedef logic [8:0] scanline_t;  // 0..261
  typedef logic [8:0] dot_t;       // 0..340
  typedef logic [8:0] scroll_t;    // x 0..511, y 0..479

  // region of the frame the raster is in
  typedef enum logic [1:0] {
    TM_VISIBLE,  // lines 0..239
    TM_POST,     // line 240
    TM_VBLANK,   // lines 241..260
    TM_PRE       // line 261
  } timer_state_t;

endpackage

`default_nettype wire

// ==== hdl/ppu_mem_pkg.sv ====
`default_nettype none

package ppu_mem_pkg;

  typedef logic [15:0] rom_addr_t;
  typedef logic [7:0]  rom_data_t;
  typedef logic [15:0] buff_addr_t;  // {screen y, screen x}

  // {palette hi, palette lo, pattern hi, pattern lo}
  typedef logic [3:0] pixel_t;

  typedef struct packed {
    logic [1:0] palette;
    logic [7:0] pat_hi;
    logic [7:0] pat_lo;
  } tile_t;

  localparam rom_addr_t NAMETABLE_BASE   = 16'h2000;
  localparam rom_addr_t NAMETABLE_STRIDE = 16'h0400;
  localparam rom_addr_t ATTRIBUTE_OFFSET = 16'd960;  // attribute table after 30x32 names
  localparam int        TILES_X          = 32;
  localparam int        TILES_Y          = 30;

  // ROM read sequence of one tile
  typedef enum logic [2:0] {
    PH_IDLE,
    PH_NAME,
    PH_ATTR,
    PH_PAT_LO,
    PH_PAT_HI
  } fetch_phase_t;

endpackage

`default_nettype wire

// ==== hdl/line_if.sv ====
`timescale 1ns/100ps
`default_nettype none

interface line_if import ppu_timing_pkg::*; ();

  logic      start;     // one clock at dot 0 of a visible line
  scanline_t line;
  scroll_t   scroll_x;
  scroll_t   scroll_y;  // world row of this line

  modport source (output start, line, scroll_x, scroll_y);
  modport sink   (input start, line, scroll_x, scroll_y);

endinterface

`default_nettype wire

// ==== hdl/tile_if.sv ====
`timescale 1ns/100ps
`default_nettype none

interface tile_if import ppu_mem_pkg::*; ();

  logic  tile_valid;  // one clock per fetched tile
  tile_t tile;
  logic  tile_req;    // one slot freed in the shifter

  modport producer (
    output tile_valid, tile,
    input  tile_req
  );

  modport consumer (
    input  tile_valid, tile,
    output tile_req
  );

endinterface

`default_nettype wire

// ==== hdl/frame_timer.sv ====
`timescale 1ns/100ps
`default_nettype none

module frame_timer import ppu_timing_pkg::*; #(
  parameter int CLKS_PER_DOT = 8
) (
  input  logic    CLK,
  input  logic    RESET,
  input  scroll_t scroll_x,
  input  scroll_t scroll_y,
  line_if.source  lines,
  output logic    clear_status,
  output logic    set_vertical_blank
);

  localparam int DW = (CLKS_PER_DOT > 1) ? $clog2(CLKS_PER_DOT) : 1;

  logic [DW-1:0] div;       // clocks within a dot
  dot_t          dot;
  scanline_t     line;
  timer_state_t  state;
  logic          dot_end, line_end, at_dot0, line_go;
  logic [9:0]    row_sum;

  assign dot_end  = div == DW'(CLKS_PER_DOT - 1);
  assign line_end = dot_end && (dot == dot_t'(DOTS_PER_LINE - 1));
  assign at_dot0  = (div == '0) && (dot == '0);
  assign line_go  = at_dot0 && (state == TM_VISIBLE);
  assign row_sum  = 10'(scroll_y) + 10'(line);

  always_ff @(posedge CLK) begin
    if (RESET) begin
      div                <= '0;
      dot                <= '0;
      line               <= '0;
      state              <= TM_VISIBLE;
      clear_status       <= 1'b0;
      set_vertical_blank <= 1'b0;
      lines.start        <= 1'b0;
    end else begin
      div <= dot_end ? '0 : div + 1'b1;
      if (dot_end)
        dot <= line_end ? '0 : dot + 1'b1;
      if (line_end) begin
        if (line == scanline_t'(LINES_PER_FRAME - 1)) begin
          line  <= '0;
          state <= TM_VISIBLE;
        end else begin
          line <= line + 1'b1;
          if (line + 1'b1 == scanline_t'(VISIBLE_LINES))
            state <= TM_POST;
          else if (line + 1'b1 == scanline_t'(VBLANK_LINE))
            state <= TM_VBLANK;
          else if (line + 1'b1 == scanline_t'(LINES_PER_FRAME - 1))
            state <= TM_PRE;
        end
      end
      clear_status       <= at_dot0 && (line == '0);
      set_vertical_blank <= at_dot0 && (state == TM_VBLANK) &&
                            (line == scanline_t'(VBLANK_LINE));
      lines.start        <= line_go;
    end
  end

  // line info held until the next line start
  always_ff @(posedge CLK) begin
    if (line_go) begin
      lines.line     <= line;
      lines.scroll_x <= scroll_x;
      // world map is two screens tall
      lines.scroll_y <= (row_sum >= 10'(2 * VISIBLE_LINES)) ?
                        scroll_t'(row_sum - 10'(2 * VISIBLE_LINES)) : scroll_t'(row_sum);
    end
  end

endmodule

`default_nettype wire

// ==== hdl/tile_locator.sv ====
`timescale 1ns/100ps
`default_nettype none

module tile_locator import ppu_mem_pkg::*, ppu_timing_pkg::*; (
  input  logic       CLK,
  input  logic [5:0] tile_col,   // 0..63 over two nametables
  input  scroll_t    world_row,
  output rom_addr_t  name_addr,
  output rom_addr_t  attr_addr,
  output logic [2:0] attr_shift
);

  logic [5:0] row_w;    // tile row 0..59
  logic       nt_v, nt_h;
  logic [4:0] row_r;    // row within the nametable
  rom_addr_t  base;

  always_comb begin
    row_w = world_row[8:3];
    nt_h  = tile_col[5];
    nt_v  = row_w >= 6'(TILES_Y);
    row_r = nt_v ? 5'(row_w - 6'(TILES_Y)) : row_w[4:0];
    base  = NAMETABLE_BASE + rom_addr_t'({nt_v, nt_h}) * NAMETABLE_STRIDE;
  end

  always_ff @(posedge CLK) begin
    name_addr  <= base + rom_addr_t'(int'(row_r) * TILES_X) +
                  rom_addr_t'(tile_col[4:0]);
    // one attribute byte per 4x4 tiles
    attr_addr  <= base + ATTRIBUTE_OFFSET + rom_addr_t'({row_r[4:2], 3'b000}) +
                  rom_addr_t'(tile_col[4:2]);
    attr_shift <= {row_r[1], tile_col[1], 1'b0};  // quadrant in the byte
  end

endmodule

`default_nettype wire

// ==== hdl/tile_fetch.sv ====
`timescale 1ns/100ps
`default_nettype none

module tile_fetch import ppu_mem_pkg::*, ppu_timing_pkg::*; (
  input  logic      CLK,
  input  logic      RESET,
  input  logic      pattern_select,
  line_if.sink      lines,
  tile_if.producer  tiles,
  output rom_addr_t rom_addr,
  input  rom_data_t rom_data
);

  fetch_phase_t phase;
  logic         sub;          // second clock of a read
  logic [1:0]   pend;         // tiles owed to the shifter
  logic [5:0]   col;
  scroll_t      row;
  rom_data_t    tile_idx, pat_lo_q;
  logic [1:0]   pal_q;
  rom_addr_t    name_addr, attr_addr, pat_addr;
  logic [2:0]   attr_shift;
  logic         begin_tile;

  tile_locator u_locator (
    .CLK       (CLK),
    .tile_col  (col),
    .world_row (row),
    .name_addr (name_addr),
    .attr_addr (attr_addr),
    .attr_shift(attr_shift)
  );

  assign begin_tile = (phase == PH_IDLE) && ((pend != '0) || tiles.tile_req);
  assign pat_addr   = {3'b000, pattern_select, tile_idx, phase == PH_PAT_HI, row[2:0]};

  always_comb begin
    case (phase)
      PH_NAME:              rom_addr = name_addr;
      PH_ATTR:              rom_addr = attr_addr;
      PH_PAT_LO, PH_PAT_HI: rom_addr = pat_addr;
      default:              rom_addr = '0;
    endcase
  end

  always_ff @(posedge CLK) begin
    if (RESET) begin
      phase            <= PH_IDLE;
      sub              <= 1'b0;
      pend             <= '0;
      tiles.tile_valid <= 1'b0;
    end else begin
      tiles.tile_valid <= 1'b0;
      if (lines.start) begin
        phase <= PH_IDLE;
        sub   <= 1'b0;
        pend  <= 2'd2;  // prefetch two tiles
      end else begin
        pend <= pend + {1'b0, tiles.tile_req} - {1'b0, begin_tile};
        if (phase == PH_IDLE) begin
          sub <= 1'b0;
          if (begin_tile)
            phase <= PH_NAME;
        end else begin
          sub <= ~sub;
          if (sub) begin
            case (phase)
              PH_NAME:   phase <= PH_ATTR;
              PH_ATTR:   phase <= PH_PAT_LO;
              PH_PAT_LO: phase <= PH_PAT_HI;
              default: begin
                phase            <= PH_IDLE;
                tiles.tile_valid <= 1'b1;
              end
            endcase
          end
        end
      end
    end
  end

  // data captured on the second clock of each read
  always_ff @(posedge CLK) begin
    if (lines.start) begin
      col <= lines.scroll_x[8:3];
      row <= lines.scroll_y;
    end else if (phase == PH_ATTR && sub) begin
      col <= col + 1'b1;  // locator settles during pattern reads
    end
    if (sub) begin
      case (phase)
        PH_NAME:   tile_idx <= rom_data;
        PH_ATTR:   pal_q    <= {rom_data[attr_shift + 3'd1], rom_data[attr_shift]};
        PH_PAT_LO: pat_lo_q <= rom_data;
        PH_PAT_HI: tiles.tile <= '{palette: pal_q, pat_hi: rom_data, pat_lo: pat_lo_q};
        default: ;
      endcase
    end
  end

endmodule

`default_nettype wire

// ==== hdl/pixel_shifter.sv ====
`timescale 1ns/100ps
`default_nettype none

module pixel_shifter import ppu_mem_pkg::*, ppu_timing_pkg::*; #(
  parameter int CLKS_PER_DOT = 8
) (
  input  logic       CLK,
  input  logic       RESET,
  line_if.sink       lines,
  tile_if.consumer   tiles,
  output logic       buff_w,
  output buff_addr_t buff_addr,
  output rom_data_t  buff_data
);

  localparam int DW = (CLKS_PER_DOT > 1) ? $clog2(CLKS_PER_DOT) : 1;

  typedef enum logic [1:0] {SH_IDLE, SH_FILL, SH_RUN} shift_state_t;

  shift_state_t  state;
  logic [DW-1:0] div;
  logic [2:0]    bit_cnt;     // shifts since last reload
  logic [2:0]    skip;        // fine-x pixels left to drop
  logic [7:0]    x;
  logic          got_first, next_valid, tick;
  logic [15:0]   pat_lo, pat_hi;
  logic [3:0]    pal;         // {current, upcoming}
  tile_t         next_tile;
  logic [7:0]    line_q;
  pixel_t        pixel;

  assign pixel = {pal[3:2], pat_hi[15], pat_lo[15]};
  // hold the dot if the reload tile is late
  assign tick  = (state == SH_RUN) && (div == DW'(CLKS_PER_DOT - 1)) &&
                 ((bit_cnt != 3'd7) || next_valid);

  always_ff @(posedge CLK) begin
    if (RESET) begin
      state          <= SH_IDLE;
      div            <= '0;
      bit_cnt        <= '0;
      skip           <= '0;
      x              <= '0;
      got_first      <= 1'b0;
      next_valid     <= 1'b0;
      tiles.tile_req <= 1'b0;
      buff_w         <= 1'b0;
    end else begin
      tiles.tile_req <= 1'b0;
      buff_w         <= 1'b0;
      if (lines.start) begin
        state      <= SH_FILL;
        div        <= '0;
        bit_cnt    <= '0;
        skip       <= lines.scroll_x[2:0];
        x          <= '0;
        got_first  <= 1'b0;
        next_valid <= 1'b0;
      end else begin
        case (state)
          SH_FILL: begin
            if (tiles.tile_valid) begin
              if (!got_first)
                got_first <= 1'b1;
              else
                next_valid <= 1'b1;
            end else if (next_valid) begin
              next_valid     <= 1'b0;  // second tile into the low half
              tiles.tile_req <= 1'b1;
              state          <= SH_RUN;
            end
          end
          SH_RUN: begin
            if (tiles.tile_valid)
              next_valid <= 1'b1;
            if (tick) begin
              div     <= '0;
              bit_cnt <= bit_cnt + 1'b1;
              if (bit_cnt == 3'd7) begin
                next_valid     <= 1'b0;
                tiles.tile_req <= 1'b1;
              end
              if (skip != '0) begin
                skip <= skip - 1'b1;
              end else begin
                buff_w <= 1'b1;
                x      <= x + 1'b1;
                if (x == 8'(SCREEN_WIDTH - 1))
                  state <= SH_IDLE;
              end
            end else if (div != DW'(CLKS_PER_DOT - 1)) begin
              div <= div + 1'b1;
            end
          end
          default: ;
        endcase
      end
    end
  end

  always_ff @(posedge CLK) begin
    if (lines.start)
      line_q <= lines.line[7:0];
    if (tiles.tile_valid) begin
      if (state == SH_FILL && !got_first) begin
        pat_lo[15:8] <= tiles.tile.pat_lo;
        pat_hi[15:8] <= tiles.tile.pat_hi;
        pal[3:2]     <= tiles.tile.palette;
      end else begin
        next_tile <= tiles.tile;
      end
    end
    if (state == SH_FILL && !tiles.tile_valid && next_valid) begin
      pat_lo[7:0] <= next_tile.pat_lo;
      pat_hi[7:0] <= next_tile.pat_hi;
      pal[1:0]    <= next_tile.palette;
    end
    if (tick) begin
      if (bit_cnt == 3'd7) begin
        pat_lo <= {pat_lo[14:7], next_tile.pat_lo};  // upcoming tile moves up
        pat_hi <= {pat_hi[14:7], next_tile.pat_hi};
        pal    <= {pal[1:0], next_tile.palette};
      end else begin
        pat_lo <= {pat_lo[14:0], 1'b0};
        pat_hi <= {pat_hi[14:0], 1'b0};
      end
      buff_addr <= {line_q, x};
      buff_data <= {4'b0000, pixel};
    end
  end

endmodule

`default_nettype wire

// ==== hdl/ppu_background.sv ====
`timescale 1ns/100ps
`default_nettype none

module ppu_background import ppu_mem_pkg::*, ppu_timing_pkg::*; #(
  parameter int CLKS_PER_DOT = 8
) (
  input  logic       CLK,
  input  logic       RESET,
  input  scroll_t    scroll_x,
  input  scroll_t    scroll_y,
  input  logic       pattern_select,
  output rom_addr_t  rom_addr,
  input  rom_data_t  rom_data,
  output buff_addr_t buff_addr,
  output rom_data_t  buff_data,
  output logic       buff_w,
  output logic       clear_status,
  output logic       set_vertical_blank
);

  line_if lines ();
  tile_if tiles ();

  frame_timer #(.CLKS_PER_DOT(CLKS_PER_DOT)) u_timer (
    .CLK               (CLK),
    .RESET             (RESET),
    .scroll_x          (scroll_x),
    .scroll_y          (scroll_y),
    .lines             (lines.source),
    .clear_status      (clear_status),
    .set_vertical_blank(set_vertical_blank)
  );

  tile_fetch u_fetch (
    .CLK           (CLK),
    .RESET         (RESET),
    .pattern_select(pattern_select),
    .lines         (lines.sink),
    .tiles         (tiles.producer),
    .rom_addr      (rom_addr),
    .rom_data      (rom_data)
  );

  pixel_shifter #(.CLKS_PER_DOT(CLKS_PER_DOT)) u_shifter (
    .CLK      (CLK),
    .RESET    (RESET),
    .lines    (lines.sink),
    .tiles    (tiles.consumer),
    .buff_w   (buff_w),
    .buff_addr(buff_addr),
    .buff_data(buff_data)
  );

endmodule

`default_nettype wire

// ==== test/ppu_model.svh ====
`ifndef PPU_MODEL_SVH
`define PPU_MODEL_SVH

localparam logic [31:0] ROM_SEED = 32'heba5c347;

rom_data_t rom [0:65535];  // whole 64K pattern and nametable space

function automatic logic [31:0] lcg_next(input logic [31:0] state);
  return state * 32'd1664525 + 32'd1013904223;
endfunction

task automatic fill_rom;
  logic [31:0] state;
  state = ROM_SEED;
  for (int a = 0; a < 65536; a++) begin
    state  = lcg_next(state);
    rom[a] = state[31:24];  // top byte has the longest period
  end
endtask

// expected pixel at screen (x, y) for a given scroll and pattern table
function automatic pixel_t model_pixel(input int x, input int y, input int sx,
                                       input int sy, input logic ps);
  int         wx, wy, col, row, row_r, nt, base;
  int         name_a, attr_a, pat_a, shift, b;
  logic [7:0] idx, attr, lo, hi;
  logic [1:0] pal;
  wx    = (sx + x) % 512;
  wy    = (sy + y) % 480;
  col   = wx / 8;        // 0..63
  row   = wy / 8;        // 0..59
  nt    = col / 32;      // left or right nametable
  row_r = row;
  if (row >= TILES_Y) begin
    nt    = nt + 2;      // lower pair of nametables
    row_r = row - TILES_Y;
  end
  base   = NAMETABLE_BASE + nt * NAMETABLE_STRIDE;
  name_a = base + row_r * TILES_X + col % 32;
  attr_a = base + ATTRIBUTE_OFFSET + (row_r / 4) * 8 + (col % 32) / 4;
  shift  = ((row_r / 2) % 2) * 4 + ((col / 2) % 2) * 2;
  idx    = rom[name_a];
  attr   = rom[attr_a];
  pal    = {attr[shift + 1], attr[shift]};
  pat_a  = (ps ? 'h1000 : 0) + idx * 16 + wy % 8;
  lo     = rom[pat_a];
  hi     = rom[pat_a + 8];  // high plane eight bytes on
  b      = 7 - wx % 8;      // leftmost pixel is bit 7
  return {pal, hi[b], lo[b]};
endfunction

`endif

// ==== test/ppu_background_tb.sv ====
`timescale 1ns/100ps
`default_nettype none

module ppu_background_tb import ppu_mem_pkg::*, ppu_timing_pkg::*; ();

  localparam int CLKS        = 2;
  localparam int VBLANK_CLKS = VBLANK_LINE * DOTS_PER_LINE * CLKS;
  localparam int FRAME_CLKS  = LINES_PER_FRAME * DOTS_PER_LINE * CLKS;
  localparam int WAIT_LIMIT  = FRAME_CLKS + 1000;

  logic       CLK, RESET;
  scroll_t    scroll_x, scroll_y;
  logic       pattern_select;
  rom_addr_t  rom_addr, rom_addr_q;
  rom_data_t  rom_data;
  buff_addr_t buff_addr, exp_addr;
  rom_data_t  buff_data;
  logic       buff_w, clear_status, set_vertical_blank;

  pixel_t     cap_pix     [0:VISIBLE_LINES-1][0:SCREEN_WIDTH-1];
  logic       cap_written [0:VISIBLE_LINES-1][0:SCREEN_WIDTH-1];

  `include "ppu_model.svh"

  ppu_background #(.CLKS_PER_DOT(CLKS)) dut (
    .CLK               (CLK),
    .RESET             (RESET),
    .scroll_x          (scroll_x),
    .scroll_y          (scroll_y),
    .pattern_select    (pattern_select),
    .rom_addr          (rom_addr),
    .rom_data          (rom_data),
    .buff_addr         (buff_addr),
    .buff_data         (buff_data),
    .buff_w            (buff_w),
    .clear_status      (clear_status),
    .set_vertical_blank(set_vertical_blank)
  );

  always #5 CLK = ~CLK;

  // address seen mid-cycle, data one clock later
  always @(negedge CLK) begin
    rom_addr_q = rom_addr;
    @(posedge CLK);
    #1 rom_data = rom[rom_addr_q];
  end

  task automatic report_error(input string msg);
    $display("%s", msg);
    $display("Test failures found");
    $fatal(1, "stopping at first error");
  endtask

  task automatic check_pixel(input string name, input pixel_t got, input pixel_t exp);
    if (got !== exp)
      report_error($sformatf("FAIL %s: got %h expected %h", name, got, exp));
  endtask

  task automatic check_addr(input string name, input buff_addr_t got,
                            input buff_addr_t exp);
    if (got !== exp)
      report_error($sformatf("FAIL %s: got %h expected %h", name, got, exp));
  endtask

  task automatic check_strobe(input string name, input logic got, input logic exp);
    if (got !== exp)
      report_error($sformatf("FAIL %s: got %h expected %h", name, got, exp));
  endtask

  // lines written in order, wrapping after the last visible line
  function automatic buff_addr_t next_write_addr(input buff_addr_t a);
    if (a[7:0] != 8'(SCREEN_WIDTH - 1))
      return {a[15:8], a[7:0] + 8'd1};
    if (a[15:8] == 8'(VISIBLE_LINES - 1))
      return '0;
    return {a[15:8] + 8'd1, 8'd0};
  endfunction

  // write capture, flags start over with each frame
  always @(negedge CLK) begin
    if (clear_status === 1'b1)
      clear_capture();
    if (buff_w === 1'b1) begin
      check_addr("buff_addr", buff_addr, exp_addr);
      check_pixel("buff_data[7:4]", buff_data[7:4], 4'h0);
      if (cap_written[buff_addr[15:8]][buff_addr[7:0]])
        report_error($sformatf("pixel x %0d y %0d was written twice",
                               buff_addr[7:0], buff_addr[15:8]));
      cap_written[buff_addr[15:8]][buff_addr[7:0]] = 1'b1;
      cap_pix[buff_addr[15:8]][buff_addr[7:0]]     = buff_data[3:0];
      exp_addr = next_write_addr(exp_addr);
    end
  end

  task automatic clear_capture;
    for (int y = 0; y < VISIBLE_LINES; y++)
      for (int x = 0; x < SCREEN_WIDTH; x++)
        cap_written[y][x] = 1'b0;
  endtask

  task automatic wait_frame_start;
    int n;
    n = 0;
    do begin
      @(negedge CLK);
      n++;
      if (n > WAIT_LIMIT)
        report_error("timed out waiting for clear_status");
    end while (clear_status !== 1'b1);
  endtask

  task automatic wait_vblank_start;
    int n;
    n = 0;
    do begin
      @(negedge CLK);
      n++;
      if (n > WAIT_LIMIT)
        report_error("timed out waiting for set_vertical_blank");
    end while (set_vertical_blank !== 1'b1);
  endtask

  task automatic test_reset_timing;
    RESET = 1'b1;
    for (int i = 0; i < 3; i++) begin
      @(posedge CLK);
      #1;
      if (i == 2)
        RESET = 1'b0;
      @(negedge CLK);  // outputs still from a reset edge
      check_strobe("clear_status", clear_status, 1'b0);
      check_strobe("set_vertical_blank", set_vertical_blank, 1'b0);
      check_strobe("buff_w", buff_w, 1'b0);
    end
    @(negedge CLK);
    check_strobe("clear_status", clear_status, 1'b1);
    for (int n = 1; n <= FRAME_CLKS; n++) begin
      @(negedge CLK);
      check_strobe("set_vertical_blank", set_vertical_blank, n == VBLANK_CLKS);
      check_strobe("clear_status", clear_status, n == FRAME_CLKS);
    end
  endtask

  task automatic test_frame(input int sx, input int sy, input logic ps);
    wait_vblank_start();
    @(posedge CLK);
    #1;
    scroll_x       = scroll_t'(sx);
    scroll_y       = scroll_t'(sy);
    pattern_select = ps;
    wait_frame_start();
    wait_vblank_start();  // last visible line long done
    for (int y = 0; y < VISIBLE_LINES; y++) begin
      for (int x = 0; x < SCREEN_WIDTH; x++) begin
        if (!cap_written[y][x])
          report_error($sformatf("pixel x %0d y %0d was never written", x, y));
        check_pixel($sformatf("pixel x %0d y %0d", x, y), cap_pix[y][x],
                    model_pixel(x, y, sx, sy, ps));
      end
    end
  endtask

  task automatic test_blank_silence;
    int n;
    n = 0;
    wait_vblank_start();
    do begin
      @(negedge CLK);
      n++;
      check_strobe("buff_w", buff_w, 1'b0);
      if (n > WAIT_LIMIT)
        report_error("timed out waiting for clear_status after vertical blank");
    end while (clear_status !== 1'b1);
  endtask

  initial begin
    CLK            = 1'b0;
    RESET          = 1'b1;
    scroll_x       = '0;
    scroll_y       = '0;
    pattern_select = 1'b0;
    rom_data       = '0;
    rom_addr_q     = '0;
    exp_addr       = '0;
    fill_rom();
    clear_capture();

    test_reset_timing();
    test_frame(0, 0, 1'b0);
    test_frame(3, 5, 1'b0);      // fine x and fine row
    test_frame(300, 470, 1'b1);  // crosses both nametable seams
    test_blank_silence();

    $display("All tests passed!");
    $finish;
  end

endmodule

`default_nettype wire

// ==== verilog.f ====
+incdir+test
hdl/ppu_timing_pkg.sv
hdl/ppu_mem_pkg.sv
hdl/line_if.sv
hdl/tile_if.sv
hdl/frame_timer.sv
hdl/tile_locator.sv
hdl/tile_fetch.sv
hdl/pixel_shifter.sv
hdl/ppu_background.sv
test/ppu_background_tb.sv

// ==== Bender.yml ====
package:
  name: ppu_background

sources:
  - files:
      - hdl/ppu_timing_pkg.sv
      - hdl/ppu_mem_pkg.sv
      - hdl/line_if.sv
      - hdl/tile_if.sv
      - hdl/frame_timer.sv
      - hdl/tile_locator.sv
      - hdl/tile_fetch.sv
      - hdl/pixel_shifter.sv
      - hdl/ppu_background.sv
  - target: test
    include_dirs:
      - test
    files:
      - test/ppu_background_tb.sv
